/* verilog/cond_pkg.sv */
// Condition unit shared definitions

package cond_pkg;

    // width of one data word and of the inversion mask
    localparam int word_width = 8;

    // number of data words carried by one request
    localparam int word_count = 4;

    // number of supported reduction operations
    // keep this in step with the enumeration below
    localparam int op_count = 6;

    // reduction operations in chained form
    // the inverting ones invert at every link of the chain and not once at the end,
    // so they do not match the built-in reduction operators
    typedef enum logic [2:0] {
        op_and  = 3'd0,
        op_nand = 3'd1,
        op_or   = 3'd2,
        op_nor  = 3'd3,
        op_xor  = 3'd4,
        op_xnor = 3'd5
    } reduce_op_t;

    // one request as it enters stage 1
    // words[0] seeds every chain and words[word_count-1] is the last link
    typedef struct packed {
        logic [word_count-1:0][word_width-1:0] words;
        reduce_op_t                            op;
        logic [word_width-1:0]                 invert_mask;
    } cond_req_t;

    // stage 1 result handed to stage 2
    // the mask rides along unchanged so both arrive in the same cycle
    typedef struct packed {
        logic [word_width-1:0] word;
        logic [word_width-1:0] invert_mask;
    } merged_t;

    // decoded condition flags, one per chained reduction of the masked word
    typedef struct packed {
        logic all_set;
        logic nand_chain;
        logic any_set;
        logic nor_chain;
        logic parity_odd;
        logic xnor_chain;
    } cond_flags_t;

endpackage

/* verilog/bit_reducer.sv */
// Chained n-input bit reducer

`timescale 1ns/1ps

module bit_reducer #(
    parameter cond_pkg::reduce_op_t operation   = cond_pkg::op_and,
    parameter int                   input_count = 2
) (
    input  logic [input_count-1:0] bits,
    output logic                   result
);

    // a reduction needs at least one input to seed the chain
    if (input_count < 1) begin : g_bad_count
        $error("bit_reducer needs input_count of at least 1, got %0d", input_count);
    end

    // bits[0] seeds the running partial result
    // every later bit is folded into it with the chosen two-input function
    // for nand, nor and xnor the inversion is applied at each link,
    // which is why a plain ~& or ~^ would give a different answer
    // a single input passes straight through for every operation
    case (operation)
        cond_pkg::op_and: begin : g_and
            always_comb begin : p_chain
                logic partial;
                partial = bits[0];
                for (int i = 1; i < input_count; i++) begin
                    partial = partial & bits[i];
                end
                result = partial;
            end
        end
        cond_pkg::op_nand: begin : g_nand
            always_comb begin : p_chain
                logic partial;
                partial = bits[0];
                for (int i = 1; i < input_count; i++) begin
                    partial = ~(partial & bits[i]);
                end
                result = partial;
            end
        end
        cond_pkg::op_or: begin : g_or
            always_comb begin : p_chain
                logic partial;
                partial = bits[0];
                for (int i = 1; i < input_count; i++) begin
                    partial = partial | bits[i];
                end
                result = partial;
            end
        end
        cond_pkg::op_nor: begin : g_nor
            always_comb begin : p_chain
                logic partial;
                partial = bits[0];
                for (int i = 1; i < input_count; i++) begin
                    partial = ~(partial | bits[i]);
                end
                result = partial;
            end
        end
        cond_pkg::op_xor: begin : g_xor
            always_comb begin : p_chain
                logic partial;
                partial = bits[0];
                for (int i = 1; i < input_count; i++) begin
                    partial = partial ^ bits[i];
                end
                result = partial;
            end
        end
        cond_pkg::op_xnor: begin : g_xnor
            always_comb begin : p_chain
                logic partial;
                partial = bits[0];
                for (int i = 1; i < input_count; i++) begin
                    partial = ~(partial ^ bits[i]);
                end
                result = partial;
            end
        end
        default: begin : g_bad_op
            // an encoding outside the enumeration stops elaboration here
            $error("bit_reducer got unsupported operation code %0d", operation);
            assign result = 1'b0;
        end
    endcase

endmodule

/* verilog/word_reducer.sv */
// Stage 1 word merge

`timescale 1ns/1ps

module word_reducer (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                req_valid,
    input  cond_pkg::cond_req_t req,
    output logic                merged_valid,
    output cond_pkg::merged_t   merged
);

    // merged word for each operation, indexed by the operation code
    logic [cond_pkg::word_width-1:0] op_words [cond_pkg::op_count];

    // word picked by the request's operation select
    logic [cond_pkg::word_width-1:0] selected;

    // every bit position is reduced on its own across all request words
    // all six operations are built side by side and the select picks one later,
    // so the op field never sits in front of the reducer chains
    for (genvar b = 0; b < cond_pkg::word_width; b++) begin : g_bit
        // column of this bit position, words[0] at index 0 seeds the chain
        logic [cond_pkg::word_count-1:0] column;

        always_comb begin
            for (int w = 0; w < cond_pkg::word_count; w++) begin
                column[w] = req.words[w][b];
            end
        end

        // one reducer per operation on the same column
        for (genvar k = 0; k < cond_pkg::op_count; k++) begin : g_op
            bit_reducer #(
                .operation   (cond_pkg::reduce_op_t'(k)),
                .input_count (cond_pkg::word_count)
            ) u_bit_reducer (
                .bits   (column),
                .result (op_words[k][b])
            );
        end
    end

    // pick the merged word for the requested operation
    // codes outside the enumeration merge to zero
    always_comb begin
        case (req.op)
            cond_pkg::op_and:  selected = op_words[cond_pkg::op_and];
            cond_pkg::op_nand: selected = op_words[cond_pkg::op_nand];
            cond_pkg::op_or:   selected = op_words[cond_pkg::op_or];
            cond_pkg::op_nor:  selected = op_words[cond_pkg::op_nor];
            cond_pkg::op_xor:  selected = op_words[cond_pkg::op_xor];
            cond_pkg::op_xnor: selected = op_words[cond_pkg::op_xnor];
            default:           selected = '0;
        endcase
    end

    // strobe is delayed by exactly one cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            merged_valid <= 1'b0;
        end else begin
            merged_valid <= req_valid;
        end
    end

    // merged word and mask only load on an accepted request
    // they hold their last value between strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            merged <= '0;
        end else if (req_valid) begin
            merged.word        <= selected;
            merged.invert_mask <= req.invert_mask;
        end
    end

    // back-to-back results can only come from back-to-back requests
    // this guards against the strobe being stretched or duplicated in stage 1
    a_merged_follows_req: assert property (
        @(posedge clk) disable iff (!arst_n)
        merged_valid && $past(merged_valid) |-> $past(req_valid, 1) && $past(req_valid, 2)
    ) else $error("merged_valid high twice without two preceding requests");

endmodule

/* verilog/condition_decoder.sv */
// Stage 2 flag decode

`timescale 1ns/1ps

module condition_decoder (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  merged_valid,
    input  cond_pkg::merged_t     merged,
    output logic                  flags_valid,
    output cond_pkg::cond_flags_t flags
);

    // merged word after selective inversion
    logic [cond_pkg::word_width-1:0] masked;

    // chained reduction of the masked word, indexed by the operation code
    logic [cond_pkg::op_count-1:0] chain;

    // next flag values, decoded combinationally from the chains
    cond_pkg::cond_flags_t flags_next;

    // a set mask bit flips that input before reduction
    // with the right mask the and chain fires on any chosen bit pattern
    assign masked = merged.word ^ merged.invert_mask;

    // all six reductions run over the same masked word
    // bit 0 seeds each chain and bit word_width-1 is the last link
    for (genvar k = 0; k < cond_pkg::op_count; k++) begin : g_op
        bit_reducer #(
            .operation   (cond_pkg::reduce_op_t'(k)),
            .input_count (cond_pkg::word_width)
        ) u_bit_reducer (
            .bits   (masked),
            .result (chain[k])
        );
    end

    // map each chain onto its named flag
    // all_set, any_set and parity_odd match the plain reductions
    // the three inverting flags follow the per-link rule
    always_comb begin
        flags_next.all_set    = chain[cond_pkg::op_and];
        flags_next.nand_chain = chain[cond_pkg::op_nand];
        flags_next.any_set    = chain[cond_pkg::op_or];
        flags_next.nor_chain  = chain[cond_pkg::op_nor];
        flags_next.parity_odd = chain[cond_pkg::op_xor];
        flags_next.xnor_chain = chain[cond_pkg::op_xnor];
    end

    // flags strobe trails merged_valid by one cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags_valid <= 1'b0;
        end else begin
            flags_valid <= merged_valid;
        end
    end

    // flags are captured only on a stage 1 strobe
    // the consumer must take them in the cycle flags_valid is high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else if (merged_valid) begin
            flags <= flags_next;
        end
    end

    // every bit set must also mean some bit set
    // a failure here points at a broken chain in bit_reducer or a swapped flag field
    a_all_implies_any: assert property (
        @(posedge clk) disable iff (!arst_n)
        flags_valid |-> (!flags.all_set || flags.any_set)
    ) else $error("all_set high without any_set");

endmodule

/* verilog/cond_unit_top.sv */
// Condition unit top level

`timescale 1ns/1ps

module cond_unit_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  req_valid,
    input  cond_pkg::cond_req_t   req,
    output logic                  flags_valid,
    output cond_pkg::cond_flags_t flags
);

    // stage 1 to stage 2 link with one strobe and its payload
    logic              merged_valid;
    cond_pkg::merged_t merged;

    // stage 1 folds the four request words into one
    word_reducer u_word_reducer (
        .clk          (clk),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .req          (req),
        .merged_valid (merged_valid),
        .merged       (merged)
    );

    // stage 2 masks the merged word and decodes the six flags
    // two cycles from request strobe to flags strobe in total
    condition_decoder u_condition_decoder (
        .clk          (clk),
        .arst_n       (arst_n),
        .merged_valid (merged_valid),
        .merged       (merged),
        .flags_valid  (flags_valid),
        .flags        (flags)
    );

endmodule

/* sim/tb_clock.sv */
// Testbench clock and reset

`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic arst_n
);

    // free running clock, low for the first half period
    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

    // reset is held for a fixed number of rising edges
    // and released on a falling edge so no register sees it change at a sampling edge
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

/* sim/tb_cond_unit.sv */
// Condition unit testbench

`timescale 1ns/1ps

module tb_cond_unit;

    logic                  clk;
    logic                  arst_n;
    logic                  req_valid;
    cond_pkg::cond_req_t   req;
    logic                  flags_valid;
    cond_pkg::cond_flags_t flags;

    // expected flags in request order, the head belongs to the oldest request in flight
    cond_pkg::cond_flags_t expected_q [$];
    // head of the queue taken in the cycle flags_valid is high
    cond_pkg::cond_flags_t exp_flags;

    int                    error_count;
    int                    sent_count;
    int                    results_seen;
    int                    waited;
    int                    op_pick;
    integer                seed;
    logic [31:0]           rnd;
    cond_pkg::cond_req_t   r;

    tb_clock #(.period_ns(8), .reset_cycles(4)) u_clock (.clk(clk), .arst_n(arst_n));

    cond_unit_top u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req         (req),
        .flags_valid (flags_valid),
        .flags       (flags)
    );

    task automatic note_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        error_count = error_count + 1;
    endtask

    task automatic report_mismatch(input string field, input logic want, input logic got);
        $display("Error at %0t ns: field %s expected %0b got %0b", $time, field, want, got);
        error_count = error_count + 1;
    endtask

    // one link of a chain, the inverting operations invert right here at every step
    function automatic logic link(input cond_pkg::reduce_op_t op, input logic acc, input logic b);
        case (op)
            cond_pkg::op_and:  return acc & b;
            cond_pkg::op_nand: return ~(acc & b);
            cond_pkg::op_or:   return acc | b;
            cond_pkg::op_nor:  return ~(acc | b);
            cond_pkg::op_xor:  return acc ^ b;
            cond_pkg::op_xnor: return ~(acc ^ b);
            default:           return 1'b0;
        endcase
    endfunction

    // bit 0 seeds the chain and bit 7 is the last link
    function automatic logic reduce_word(input cond_pkg::reduce_op_t op,
                                         input logic [cond_pkg::word_width-1:0] w);
        logic acc;
        acc = w[0];
        for (int i = 1; i < cond_pkg::word_width; i++) begin
            acc = link(op, acc, w[i]);
        end
        return acc;
    endfunction

    // stage 1 reference, each bit column is chained from words[0] to words[3]
    function automatic logic [cond_pkg::word_width-1:0] merge_words(input cond_pkg::cond_req_t q);
        logic [cond_pkg::word_width-1:0] merged_word;
        logic                            acc;
        for (int b = 0; b < cond_pkg::word_width; b++) begin
            acc = q.words[0][b];
            for (int w = 1; w < cond_pkg::word_count; w++) begin
                acc = link(q.op, acc, q.words[w][b]);
            end
            merged_word[b] = acc;
        end
        return merged_word;
    endfunction

    function automatic cond_pkg::cond_flags_t expected_flags(input cond_pkg::cond_req_t q);
        cond_pkg::cond_flags_t           f;
        logic [cond_pkg::word_width-1:0] masked;
        masked       = merge_words(q) ^ q.invert_mask;
        f.all_set    = reduce_word(cond_pkg::op_and, masked);
        f.nand_chain = reduce_word(cond_pkg::op_nand, masked);
        f.any_set    = reduce_word(cond_pkg::op_or, masked);
        f.nor_chain  = reduce_word(cond_pkg::op_nor, masked);
        f.parity_odd = reduce_word(cond_pkg::op_xor, masked);
        f.xnor_chain = reduce_word(cond_pkg::op_xnor, masked);
        return f;
    endfunction

    function automatic cond_pkg::cond_req_t build_request(input logic [7:0] w0, input logic [7:0] w1,
        input logic [7:0] w2, input logic [7:0] w3, input int op, input logic [7:0] mask);
        cond_pkg::cond_req_t q;
        q.words[0]    = w0;
        q.words[1]    = w1;
        q.words[2]    = w2;
        q.words[3]    = w3;
        q.op          = cond_pkg::reduce_op_t'(op[2:0]);
        q.invert_mask = mask;
        return q;
    endfunction

    // called on a falling edge, holds the strobe for exactly one cycle
    task automatic send_request(input cond_pkg::cond_req_t q);
        req       = q;
        req_valid = 1'b1;
        expected_q.push_back(expected_flags(q));
        sent_count = sent_count + 1;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // flags are stable at the falling edge, so the matching expectation is taken here
    always @(negedge clk) begin
        if (arst_n && flags_valid) begin
            results_seen = results_seen + 1;
            assert (expected_q.size() > 0)
                else note_error("flags_valid arrived with no request outstanding");
            if (expected_q.size() > 0) begin
                exp_flags = expected_q.pop_front();
            end
        end
    end

    // quiet output while reset is applied and in the first cycle after it
    a_reset_quiet: assert property (@(posedge clk) (!arst_n || !$past(arst_n)) |-> !flags_valid)
        else note_error("flags_valid high during reset or in the first cycle after it");

    // one result per request, two cycles after the strobe was sampled
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        flags_valid == $past(req_valid, 2))
        else note_error("flags_valid does not follow the request strobe two cycles earlier");

    a_all_set: assert property (@(posedge clk) disable iff (!arst_n)
        flags_valid |-> (flags.all_set == exp_flags.all_set))
        else report_mismatch("all_set", $sampled(exp_flags.all_set), $sampled(flags.all_set));
    a_nand_chain: assert property (@(posedge clk) disable iff (!arst_n)
        flags_valid |-> (flags.nand_chain == exp_flags.nand_chain))
        else report_mismatch("nand_chain", $sampled(exp_flags.nand_chain),
                             $sampled(flags.nand_chain));
    a_any_set: assert property (@(posedge clk) disable iff (!arst_n)
        flags_valid |-> (flags.any_set == exp_flags.any_set))
        else report_mismatch("any_set", $sampled(exp_flags.any_set), $sampled(flags.any_set));
    a_nor_chain: assert property (@(posedge clk) disable iff (!arst_n)
        flags_valid |-> (flags.nor_chain == exp_flags.nor_chain))
        else report_mismatch("nor_chain", $sampled(exp_flags.nor_chain),
                             $sampled(flags.nor_chain));
    a_parity_odd: assert property (@(posedge clk) disable iff (!arst_n)
        flags_valid |-> (flags.parity_odd == exp_flags.parity_odd))
        else report_mismatch("parity_odd", $sampled(exp_flags.parity_odd),
                             $sampled(flags.parity_odd));
    a_xnor_chain: assert property (@(posedge clk) disable iff (!arst_n)
        flags_valid |-> (flags.xnor_chain == exp_flags.xnor_chain))
        else report_mismatch("xnor_chain", $sampled(exp_flags.xnor_chain),
                             $sampled(flags.xnor_chain));

    initial begin
        req_valid    = 1'b0;
        req          = '0;
        exp_flags    = '0;
        error_count  = 0;
        sent_count   = 0;
        results_seen = 0;
        seed         = 99323;

        waited = 0;
        while (!arst_n && waited < 20) begin
            @(negedge clk);
            waited = waited + 1;
        end

        if (!arst_n) begin
            note_error("reset was never released");
        end else begin
            @(negedge clk);
            // all ones, all zeros and alternating words through every op, back to back
            for (int k = 0; k < cond_pkg::op_count; k++) begin
                send_request(build_request(8'hFF, 8'hFF, 8'hFF, 8'hFF, k, 8'h00));
            end
            for (int k = 0; k < cond_pkg::op_count; k++) begin
                send_request(build_request(8'h00, 8'h00, 8'h00, 8'h00, k, 8'h00));
            end
            for (int k = 0; k < cond_pkg::op_count; k++) begin
                send_request(build_request(8'hAA, 8'h55, 8'hAA, 8'h55, k, 8'h0F));
            end
            // columns 1,1,0,1 under nand and 0,0,1,0 under nor, where per-link inversion
            // and the reduction operators part ways, then xnor over four ones
            send_request(build_request(8'hFF, 8'hFF, 8'h00, 8'hFF, 1, 8'h00));
            send_request(build_request(8'h00, 8'h00, 8'hFF, 8'h00, 3, 8'h00));
            send_request(build_request(8'hFF, 8'hFF, 8'hFF, 8'hFF, 5, 8'h00));
            @(negedge clk);
            // a mask equal to the merged word leaves an all zero word for stage 2
            for (int k = 0; k < cond_pkg::op_count; k++) begin
                r             = build_request(8'h3C, 8'hF0, 8'h5A, 8'h99, k, 8'h00);
                r.invert_mask = merge_words(r);
                send_request(r);
            end

            // random traffic with zero or one idle cycle between requests
            for (int n = 0; n < 200; n++) begin
                rnd        = $random(seed);
                r.words[0] = rnd[7:0];
                r.words[1] = rnd[15:8];
                r.words[2] = rnd[23:16];
                r.words[3] = rnd[31:24];
                op_pick    = {$random(seed)} % 6;
                r.op       = cond_pkg::reduce_op_t'(op_pick[2:0]);
                rnd        = $random(seed);
                r.invert_mask = rnd[7:0];
                send_request(r);
                if (rnd[8]) begin
                    @(negedge clk);
                end
            end

            waited = 0;
            while (expected_q.size() != 0 && waited < 10) begin
                @(negedge clk);
                waited = waited + 1;
            end
            if (expected_q.size() != 0) begin
                $display("Timed out waiting for %0d outstanding results", expected_q.size());
                error_count = error_count + 1;
            end
            // the last popped expectation is compared on the next rising edge
            repeat (2) @(negedge clk);
            assert (results_seen == sent_count)
                else note_error("number of results differs from number of requests");
        end

        $display("Requests %0d, results %0d, errors %0d", sent_count, results_seen, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/cond_pkg.sv
verilog/bit_reducer.sv
verilog/word_reducer.sv
verilog/condition_decoder.sv
verilog/cond_unit_top.sv
sim/tb_clock.sv
sim/tb_cond_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_cond_unit \
    --Mdir obj_dir \
    -o sim_cond_unit \
    -f verilog.f

output="$(./obj_dir/sim_cond_unit)"
echo "$output"

if grep -qx "Done: no errors" <<< "$output"; then
    exit 0
else
    exit 1
fi
